// File: booth/booth_accu.sv
`timescale 1ns/1ps

module booth_accu (
	input logic signed [booth_pkg::booth_width+1:0] accu_in,
	input logic signed [booth_pkg::booth_width-1:0] m_value,
	input booth_pkg::accu_mode_e mode,
	output logic signed [booth_pkg::booth_width+1:0] accu_out
);

	logic signed [booth_pkg::booth_width+1:0] m_ext;
	logic signed [booth_pkg::booth_width+1:0] addend;

	// two guard bits keep 2M and its sign inside the partial product
	assign m_ext = {{2{m_value[booth_pkg::booth_width-1]}}, m_value};

	always_comb begin
		case (mode)
			booth_pkg::accu_add_2m,
			booth_pkg::accu_sub_2m: addend = m_ext <<< 1;
			default: addend = m_ext;
		endcase
	end

	always_comb begin
		case (mode)
			booth_pkg::accu_sub_m,
			booth_pkg::accu_sub_2m: accu_out = accu_in - addend;
			default: accu_out = accu_in + addend;
		endcase
	end

	// ##################################################
	// mode bits, for reference
	// ##################################################
	// bit 1 selects the doubled multiplicand
	// bit 0 selects subtraction

	// the adder wraps at the register width and the
	// Booth recoding keeps every partial sum in range

endmodule

// File: booth/booth_control.sv
`timescale 1ns/1ps

module booth_control (
	input logic CLK,
	input logic RESET,
	input logic req,
	input logic [2:0] digit,
	output booth_pkg::booth_ctrl_t ctrl,
	output logic done
);

	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_op,
		st_shift,
		st_notify
	} state_e;

	state_e state_q;
	state_e state_next;
	logic [booth_pkg::booth_count_width-1:0] count_q;
	logic hi_clear_q;
	logic lo_clear_q;
	logic x_clear_q;

	// ##################################################
	// sequencing
	// ##################################################

	always_comb begin
		state_next = state_q;
		case (state_q)
			st_idle: if (req) state_next = st_load;
			st_load: state_next = st_op;
			st_op: state_next = st_shift;
			st_shift: begin
				if (count_q == booth_pkg::booth_count_width'(booth_pkg::booth_iterations)) begin
					state_next = st_notify;
				end else begin
					state_next = st_op;
				end
			end
			st_notify: if (!req) state_next = st_idle; // held req keeps us here
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			state_q <= st_idle;
			count_q <= '0;
			done <= 1'b0;
		end else begin
			state_q <= state_next;
			if (state_q == st_load) begin
				count_q <= '0;
			end else if (state_q == st_op) begin
				count_q <= count_q + 1'b1; // one count per add step
			end
			done <= (state_q == st_notify) && req; // drops on the same edge that leaves notify
		end
	end

	// clears are asserted out of reset and again for the load cycle
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			hi_clear_q <= 1'b0;
			lo_clear_q <= 1'b0;
			x_clear_q <= 1'b0;
		end else begin
			hi_clear_q <= (state_next != st_load);
			lo_clear_q <= 1'b1; // the low register is loaded, never cleared, in load
			x_clear_q <= (state_next != st_load);
		end
	end

	// ##################################################
	// datapath control
	// ##################################################

	always_comb begin
		ctrl = '0;
		ctrl.hi_clear = hi_clear_q;
		ctrl.lo_clear = lo_clear_q;
		ctrl.x_clear = x_clear_q;
		ctrl.accu_mode = booth_pkg::accu_add_m;
		case (state_q)
			st_load: begin
				ctrl.m_enable = 1'b1;
				ctrl.lo_enable = 1'b1;
				ctrl.lo_mode = 1'b1; // take the multiplier
			end
			st_op: begin
				ctrl.hi_mode = 1'b1;
				case (digit)
					3'b001, 3'b010: begin
						ctrl.hi_enable = 1'b1;
						ctrl.accu_mode = booth_pkg::accu_add_m;
					end
					3'b011: begin
						ctrl.hi_enable = 1'b1;
						ctrl.accu_mode = booth_pkg::accu_add_2m;
					end
					3'b100: begin
						ctrl.hi_enable = 1'b1;
						ctrl.accu_mode = booth_pkg::accu_sub_2m;
					end
					3'b101, 3'b110: begin
						ctrl.hi_enable = 1'b1;
						ctrl.accu_mode = booth_pkg::accu_sub_m;
					end
					default: ctrl.hi_enable = 1'b0; // 000 and 111 leave the partial product alone
				endcase
			end
			st_shift: begin
				ctrl.hi_enable = 1'b1;
				ctrl.lo_enable = 1'b1;
				ctrl.x_enable = 1'b1;
			end
			default: ctrl.hi_enable = 1'b0;
		endcase
	end

endmodule

// File: booth/booth_datapath.sv
`timescale 1ns/1ps

module booth_datapath (
	input logic CLK,
	input logic RESET,
	input booth_pkg::booth_ctrl_t ctrl,
	input booth_pkg::booth_req_t operands,
	input logic [booth_pkg::booth_width+1:0] accu_out,
	output logic [booth_pkg::booth_width+1:0] accu_in,
	output logic [booth_pkg::booth_width-1:0] m_value,
	output logic [2:0] digit,
	output booth_pkg::booth_rsp_t result
);

	logic [booth_pkg::booth_width-1:0] m_q;
	logic [booth_pkg::booth_width+1:0] hi_q;
	logic [booth_pkg::booth_width-1:0] lo_q;
	logic x_q;
	logic [booth_pkg::booth_width+1:0] hi_shift;
	logic [booth_pkg::booth_width-1:0] lo_shift;

	// ##################################################
	// shift chain {hi, lo, x}
	// ##################################################

	// sign fills from the top
	assign hi_shift = {{2{hi_q[booth_pkg::booth_width+1]}}, hi_q[booth_pkg::booth_width+1:2]};
	assign lo_shift = {hi_q[1:0], lo_q[booth_pkg::booth_width-1:2]};

	always_ff @(posedge CLK) begin
		if (ctrl.m_enable) begin
			m_q <= operands.multiplicand;
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			hi_q <= '0;
		end else if (!ctrl.hi_clear) begin
			hi_q <= '0;
		end else if (ctrl.hi_enable) begin
			hi_q <= ctrl.hi_mode ? accu_out : hi_shift;
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			lo_q <= '0;
		end else if (!ctrl.lo_clear) begin
			lo_q <= '0;
		end else if (ctrl.lo_enable) begin
			lo_q <= ctrl.lo_mode ? operands.multiplier : lo_shift;
		end
	end

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			x_q <= 1'b0;
		end else if (!ctrl.x_clear) begin
			x_q <= 1'b0;
		end else if (ctrl.x_enable) begin
			x_q <= lo_q[1]; // last bit shifted out of the low register
		end
	end

	// ##################################################
	// outputs
	// ##################################################

	assign accu_in = hi_q;
	assign m_value = m_q;
	assign digit = {lo_q[1:0], x_q};

	// the two guard bits of hi are pure sign once all iterations are done
	assign result.product = {hi_q[booth_pkg::booth_width-1:0], lo_q};

endmodule

// File: common/booth_pkg.sv
package booth_pkg;

	// ##################################################
	// sizes
	// ##################################################

	localparam int booth_width = 8; // operand width
	localparam int booth_iterations = booth_width / 2; // two multiplier bits per iteration
	localparam int booth_count_width = 3; // wide enough to reach booth_iterations

	// ##################################################
	// requester side
	// ##################################################

	typedef struct packed {
		logic signed [booth_width-1:0] multiplicand;
		logic signed [booth_width-1:0] multiplier;
	} booth_req_t;

	typedef struct packed {
		logic signed [2*booth_width-1:0] product;
	} booth_rsp_t;

	// ##################################################
	// controller to datapath
	// ##################################################

	typedef enum logic [1:0] {
		accu_add_m = 2'b00,
		accu_sub_m = 2'b01,
		accu_add_2m = 2'b10,
		accu_sub_2m = 2'b11
	} accu_mode_e;

	typedef struct packed {
		logic m_enable;
		logic hi_enable;
		logic lo_enable;
		logic x_enable;
		logic hi_clear; // active low
		logic lo_clear; // active low
		logic x_clear; // active low
		logic hi_mode; // 1 loads the accumulator result, 0 shifts
		logic lo_mode; // 1 loads the multiplier, 0 shifts
		accu_mode_e accu_mode;
	} booth_ctrl_t;

endpackage

// File: hw/booth_mult_top.sv
`timescale 1ns/1ps

module booth_mult_top (
	input logic CLK,
	input logic RESET,
	input logic req,
	input booth_pkg::booth_req_t operands,
	output logic done,
	output booth_pkg::booth_rsp_t result
);

	booth_pkg::booth_ctrl_t ctrl;
	logic [2:0] digit;
	logic [booth_pkg::booth_width+1:0] accu_in;
	logic [booth_pkg::booth_width+1:0] accu_out;
	logic [booth_pkg::booth_width-1:0] m_value;

	// ##################################################
	// sequencing, storage and arithmetic
	// ##################################################

	booth_control booth_control_i (
		.CLK(CLK),
		.RESET(RESET),
		.req(req),
		.digit(digit),
		.ctrl(ctrl),
		.done(done)
	);

	booth_datapath booth_datapath_i (
		.CLK(CLK),
		.RESET(RESET),
		.ctrl(ctrl),
		.operands(operands),
		.accu_out(accu_out),
		.accu_in(accu_in),
		.m_value(m_value),
		.digit(digit),
		.result(result)
	);

	booth_accu booth_accu_i (
		.accu_in(accu_in),
		.m_value(m_value),
		.mode(ctrl.accu_mode), // decoded from the digit in the op step
		.accu_out(accu_out)
	);

endmodule

// File: sim/booth_mult_chk.sv
`timescale 1ns/1ps

module booth_mult_chk (
	input logic CLK,
	input logic RESET,
	input logic req,
	input logic done,
	input booth_pkg::booth_rsp_t result
);

	int assert_failures = 0; // read by the testbench at the end of the run

	// ##################################################
	// handshake
	// ##################################################

	done_follows_req: assert property (@(posedge CLK) disable iff (!RESET)
		(!req && done) |=> !done)
		else begin
			$error("done stayed high for more than one cycle with req low");
			assert_failures++;
		end

	result_held: assert property (@(posedge CLK) disable iff (!RESET)
		done |=> (!done || $stable(result)))
		else begin
			$error("result changed while done was high");
			assert_failures++;
		end

	// ##################################################
	// reset
	// ##################################################

	done_low_in_reset: assert property (@(posedge CLK) !RESET |-> !done)
		else begin
			$error("done was high during reset");
			assert_failures++;
		end

	done_low_after_reset: assert property (@(posedge CLK) $rose(RESET) |-> !done)
		else begin
			$error("done was high on the first edge after reset");
			assert_failures++;
		end

endmodule

bind booth_mult_top booth_mult_chk booth_mult_chk_i (
	.CLK(CLK),
	.RESET(RESET),
	.req(req),
	.done(done),
	.result(result)
);

// File: sim/booth_mult_tb.sv
`timescale 1ns/1ps

module booth_mult_tb;

	typedef struct packed {
		booth_pkg::booth_req_t ops;
		booth_pkg::booth_rsp_t exp;
		logic [3:0] hold; // extra cycles with req held after done
		logic scramble; // change operands once the load step is over
	} stim_t;

	logic CLK;
	logic RESET;
	logic req;
	booth_pkg::booth_req_t operands;
	logic done;
	booth_pkg::booth_rsp_t result;

	stim_t table_q[$];
	logic [31:0] lcg_state;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int timeout_cycles = 40;

	booth_mult_top booth_mult_top_i (
		.CLK(CLK),
		.RESET(RESET),
		.req(req),
		.operands(operands),
		.done(done),
		.result(result)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ##################################################
	// stimulus table
	// ##################################################

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_row(input int a, input int b, input int hold, input logic scramble);
		stim_t row;
		row.ops.multiplicand = a[booth_pkg::booth_width-1:0];
		row.ops.multiplier = b[booth_pkg::booth_width-1:0];
		row.exp.product = 16'(a * b); // signed product of the pair
		row.hold = hold[3:0];
		row.scramble = scramble;
		table_q.push_back(row);
	endtask

	task automatic build_table();
		int a;
		int b;
		add_row(0, 0, 0, 1'b0);
		add_row(1, -1, 2, 1'b0);
		add_row(127, 127, 3, 1'b1);
		add_row(-128, -128, 1, 1'b0);
		add_row(-128, 127, 0, 1'b1);
		add_row(85, -86, 4, 1'b0);
		lcg_state = 32'd13;
		for (int i = 0; i < 10; i++) begin
			lcg_state = lcg_next(lcg_state);
			a = $signed(lcg_state[23:16]);
			lcg_state = lcg_next(lcg_state);
			b = $signed(lcg_state[23:16]);
			add_row(a, b, lcg_state[27:26], lcg_state[30]);
		end
	endtask

	// ##################################################
	// checks
	// ##################################################

	task automatic check_result(input booth_pkg::booth_rsp_t got,
			input booth_pkg::booth_rsp_t exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s result %0d, expected %0d", $time, what,
				got.product, exp.product);
			error_count++;
		end
	endtask

	task automatic check_done(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s done is %b, expected %b", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic run_product(input stim_t row, input int index);
		int errors_before;
		int edges;
		logic seen;
		logic fell;
		logic timed_out;
		errors_before = error_count;
		timed_out = 1'b0;
		@(posedge CLK);
		req <= 1'b1;
		operands <= row.ops;
		@(posedge CLK); // this edge samples req in idle
		edges = 0;
		seen = 1'b0;
		while (!seen && edges < timeout_cycles) begin
			@(posedge CLK);
			edges++;
			if (row.scramble && edges == 2) begin
				operands <= ~row.ops; // load step is already over
			end
			@(negedge CLK);
			check_done(done, edges >= 10, "latency"); // done rises on the tenth edge
			seen = done;
		end
		if (!seen) begin
			$display("test %0d: done never came within %0d cycles", index, timeout_cycles);
			timed_out = 1'b1;
		end else begin
			check_result(result, row.exp, "product");
			for (int h = 0; h < row.hold; h++) begin
				@(posedge CLK);
				@(negedge CLK);
				check_done(done, 1'b1, "held req");
				check_result(result, row.exp, "held req");
			end
		end
		@(posedge CLK);
		req <= 1'b0;
		edges = 0;
		fell = 1'b0;
		while (!fell && edges < timeout_cycles) begin
			@(posedge CLK);
			edges++;
			@(negedge CLK);
			fell = !done;
		end
		if (!fell) begin
			$display("test %0d: done never fell after req was dropped", index);
			timed_out = 1'b1;
		end else if (edges > 2) begin
			$display("Error at %0t: done fell %0d cycles after req", $time, edges);
			error_count++;
		end
		if (!timed_out && error_count == errors_before) begin
			pass_count++;
			$display("test %0d: %0d x %0d = %0d ok", index, row.ops.multiplicand,
				row.ops.multiplier, row.exp.product);
		end else begin
			fail_count++;
			$display("test %0d: %0d x %0d failed", index, row.ops.multiplicand,
				row.ops.multiplier);
		end
	endtask

	task automatic reset_mid_operation(input stim_t row, input int index);
		int errors_before;
		errors_before = error_count;
		@(posedge CLK);
		req <= 1'b1;
		operands <= row.ops;
		repeat (6) @(posedge CLK); // somewhere in the op/shift steps
		RESET <= 1'b0; // req stays high, so a surviving FSM would raise done
		for (int c = 0; c < 8; c++) begin
			@(negedge CLK);
			check_done(done, 1'b0, "reset");
			@(posedge CLK);
		end
		RESET <= 1'b1;
		req <= 1'b0;
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %0d: reset in mid operation ok", index);
		end else begin
			fail_count++;
			$display("test %0d: reset in mid operation failed", index);
		end
	endtask

	// ##################################################
	// main sequence
	// ##################################################

	initial begin
		RESET = 1'b0;
		req = 1'b0;
		operands = '0;
		build_table();
		repeat (5) @(posedge CLK);
		RESET <= 1'b1;
		@(negedge CLK);
		check_done(done, 1'b0, "after reset");
		for (int i = 0; i < table_q.size(); i++) begin
			run_product(table_q[i], i);
		end
		reset_mid_operation(table_q[4], table_q.size());
		run_product(table_q[4], table_q.size() + 1); // first product after the reset
		$display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
			pass_count + fail_count, pass_count, fail_count, error_count,
			booth_mult_top_i.booth_mult_chk_i.assert_failures);
		if (fail_count == 0 && error_count == 0
				&& booth_mult_top_i.booth_mult_chk_i.assert_failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
common/booth_pkg.sv
booth/booth_accu.sv
booth/booth_control.sv
booth/booth_datapath.sv
hw/booth_mult_top.sv
sim/booth_mult_chk.sv
sim/booth_mult_tb.sv
